// File: include/rvCore_config.svh
`ifndef RVCORE_CONFIG_SVH
`define RVCORE_CONFIG_SVH

////////////////////////////////////////
// Core sizing
////////////////////////////////////////
`define RV_XLEN 32
`define RV_REGS 32

// Data memory depth counted in 32-bit words, power of two
`define RV_DMEM_WORDS 256

`define RV_RESET_PC 32'h0000_0000

`endif

// File: design/rvPkg.sv
`include "rvCore_config.svh"

package rvPkg;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////
    typedef enum logic [6:0] {
        OP     = 7'b0110011,               // Register-register ALU
        OP_IMM = 7'b0010011,               // Register-immediate ALU
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcodeE;

    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b0001,
        AND  = 4'b0010,
        SLT  = 4'b0011,
        OR   = 4'b0100,
        SLTU = 4'b0101,
        XOR  = 4'b1000,
        SRL  = 4'b1001,
        SLL  = 4'b1010,
        SRA  = 4'b1100
    } aluOpE;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memSizeE;

    typedef enum logic [2:0] {
        NONE = 3'd0,                       // Not a branch
        EQ   = 3'd1,
        NE   = 3'd2,
        LT   = 3'd3,
        GE   = 3'd4,
        LTU  = 3'd5,
        GEU  = 3'd6
    } branchKindE;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////
    typedef struct packed {
        logic       regWrite;
        aluOpE      aluOp;
        logic       memRead;
        logic       memWrite;
        logic       memToReg;
        logic       aluSrcImm;              // Second operand is the immediate
        memSizeE    memSize;
        logic       loadUnsigned;
        branchKindE branchKind;
        logic       jump;                   // JAL or JALR
        logic       jumpReg;                // JALR only
    } ctrlT;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } wbT;

endpackage

// File: design/controlUnit.sv
module controlUnit (
    input  logic [31:0] instr,
    output rvPkg::ctrlT ctrl
);

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;    // SUB and SRA/SRAI

    rvPkg::opcodeE opcode;
    logic [2:0]    func3;
    logic [6:0]    func7;
    logic          isImm;
    rvPkg::aluOpE  aluSel;
    logic          aluLegal;

    assign opcode = rvPkg::opcodeE'(instr[6:0]);
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];
    assign isImm  = (opcode == rvPkg::OP_IMM);

    ////////////////////////////////////////
    // ALU operation for OP and OP_IMM
    ////////////////////////////////////////
    always_comb
    begin
        case (func3)
            3'b000:  aluSel = (!isImm && func7 == f7Alt) ? rvPkg::SUB : rvPkg::ADD;
            3'b001:  aluSel = rvPkg::SLL;
            3'b010:  aluSel = rvPkg::SLT;
            3'b011:  aluSel = rvPkg::SLTU;
            3'b100:  aluSel = rvPkg::XOR;
            3'b101:  aluSel = (func7 == f7Alt) ? rvPkg::SRA : rvPkg::SRL;
            3'b110:  aluSel = rvPkg::OR;
            default: aluSel = rvPkg::AND;
        endcase
        if (isImm)                                  // func7 only matters for shifts
            aluLegal = (func3 == 3'b001) ? (func7 == f7Base) :
                       (func3 == 3'b101) ? (func7 == f7Base || func7 == f7Alt) : 1'b1;
        else
            aluLegal = (func7 == f7Base) ||
                       (func7 == f7Alt && (func3 == 3'b000 || func3 == 3'b101));
    end

    ////////////////////////////////////////
    // Main decode
    ////////////////////////////////////////
    always_comb
    begin
        ctrl = '0;                                  // Unknown encodings retire as no-ops
        case (opcode)
            rvPkg::OP, rvPkg::OP_IMM:
            begin
                ctrl.regWrite  = aluLegal;
                ctrl.aluOp     = aluSel;
                ctrl.aluSrcImm = isImm;
            end
            rvPkg::LOAD:
            begin
                if (func3 != 3'b011 && func3[1:0] != 2'b11 && func3 != 3'b110)
                begin
                    ctrl.regWrite     = 1'b1;
                    ctrl.memRead      = 1'b1;
                    ctrl.memToReg     = 1'b1;
                    ctrl.aluSrcImm    = 1'b1;
                    ctrl.memSize      = rvPkg::memSizeE'(func3[1:0]);
                    ctrl.loadUnsigned = func3[2];   // LBU, LHU
                end
            end
            rvPkg::STORE:
            begin
                if (!func3[2] && func3[1:0] != 2'b11)
                begin
                    ctrl.memWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.memSize   = rvPkg::memSizeE'(func3[1:0]);
                end
            end
            rvPkg::BRANCH:
            begin
                ctrl.aluOp = rvPkg::SUB;            // Compare rs1 against rs2
                case (func3)
                    3'b000:  ctrl.branchKind = rvPkg::EQ;
                    3'b001:  ctrl.branchKind = rvPkg::NE;
                    3'b100:  ctrl.branchKind = rvPkg::LT;
                    3'b101:  ctrl.branchKind = rvPkg::GE;
                    3'b110:  ctrl.branchKind = rvPkg::LTU;
                    3'b111:  ctrl.branchKind = rvPkg::GEU;
                    default: ctrl.branchKind = rvPkg::NONE;
                endcase
            end
            rvPkg::JAL:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
            end
            rvPkg::JALR:
            begin
                ctrl.regWrite  = (func3 == 3'b000);
                ctrl.aluSrcImm = 1'b1;              // Target is rs1 + imm
                ctrl.jump      = (func3 == 3'b000);
                ctrl.jumpReg   = (func3 == 3'b000);
            end
            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: design/immGen.sv
`include "rvCore_config.svh"

module immGen (
    input  logic [31:0]         instr,
    output logic [`RV_XLEN-1:0] imm
);

    rvPkg::opcodeE opcode;
    logic          sign;

    assign opcode = rvPkg::opcodeE'(instr[6:0]);
    assign sign   = instr[31];

    always_comb
    begin
        case (opcode)
            rvPkg::OP_IMM, rvPkg::LOAD, rvPkg::JALR:
            begin
                imm = {{(`RV_XLEN-12){sign}}, instr[31:20]};                        // I
            end
            rvPkg::STORE:
            begin
                imm = {{(`RV_XLEN-12){sign}}, instr[31:25], instr[11:7]};           // S
            end
            rvPkg::BRANCH:
            begin
                imm = {{(`RV_XLEN-13){sign}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};                             // B
            end
            rvPkg::JAL:
            begin
                imm = {{(`RV_XLEN-21){sign}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};                               // J
            end
            default:
            begin
                imm = '0;                       // OP has no immediate
            end
        endcase
    end

endmodule

// File: design/regFile.sv
`include "rvCore_config.svh"

module regFile (
    input  logic                clk,
    input  logic                arstN,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2,
    input  logic                we,
    input  logic [4:0]          rd,
    input  logic [`RV_XLEN-1:0] wdata
);

    logic [`RV_XLEN-1:0] regs [`RV_REGS];

    // Combinational read, x0 stays at its reset value
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < `RV_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && rd != 5'd0)              // Drop writes to x0
        begin
            regs[rd] <= wdata;
        end
    end

endmodule

// File: design/alu.sv
`include "rvCore_config.svh"

module alu (
    input  rvPkg::aluOpE        op,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    output logic [`RV_XLEN-1:0] result,
    output logic                eq,
    output logic                lt,
    output logic                ltu
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    ////////////////////////////////////////
    // Compare flags for branches and SLT
    ////////////////////////////////////////
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb
    begin
        case (op)
            rvPkg::ADD:  result = a + b;
            rvPkg::SUB:  result = a - b;
            rvPkg::AND:  result = a & b;
            rvPkg::OR:   result = a | b;
            rvPkg::XOR:  result = a ^ b;
            rvPkg::SLL:  result = a << shamt;
            rvPkg::SRL:  result = a >> shamt;
            rvPkg::SRA:  result = $signed(a) >>> shamt;     // Keeps the sign bit
            rvPkg::SLT:
            begin
                result = {{(`RV_XLEN-1){1'b0}}, lt};
            end
            rvPkg::SLTU:
            begin
                result = {{(`RV_XLEN-1){1'b0}}, ltu};
            end
            default:
            begin
                result = '0;                    // Unused op codes
            end
        endcase
    end

endmodule

// File: design/dataMem.sv
`include "rvCore_config.svh"

module dataMem (
    input  logic                clk,
    input  logic [`RV_XLEN-1:0] addr,
    input  logic [`RV_XLEN-1:0] wdata,
    input  logic                we,
    input  rvPkg::memSizeE      size,
    input  logic                loadUnsigned,
    output logic [`RV_XLEN-1:0] rdata
);

    localparam int laneCount = `RV_XLEN / 8;
    localparam int idxWidth  = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0]  mem [`RV_DMEM_WORDS];
    logic [idxWidth-1:0]  wordIdx;
    logic [laneCount-1:0] laneMask;
    logic [`RV_XLEN-1:0]  laneData;
    logic [`RV_XLEN-1:0]  shifted;

    assign wordIdx = addr[2 +: idxWidth];   // Wraps at the memory depth

    ////////////////////////////////////////
    // Store lanes
    ////////////////////////////////////////
    always_comb
    begin
        case (size)
            rvPkg::BYTE:
            begin
                laneMask = laneCount'(1) << addr[1:0];
                laneData = {laneCount{wdata[7:0]}};
            end
            rvPkg::HALF:
            begin
                laneMask = laneCount'(3) << {addr[1], 1'b0};
                laneData = {(laneCount/2){wdata[15:0]}};
            end
            default:
            begin
                laneMask = '1;
                laneData = wdata;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            for (int i = 0; i < laneCount; i++)
            begin
                if (laneMask[i])
                    mem[wordIdx][i*8 +: 8] <= laneData[i*8 +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // Load alignment and extension
    ////////////////////////////////////////
    assign shifted = mem[wordIdx] >> {addr[1:0], 3'b000};

    always_comb
    begin
        case (size)
            rvPkg::BYTE: rdata = {{(`RV_XLEN-8){!loadUnsigned && shifted[7]}}, shifted[7:0]};
            rvPkg::HALF: rdata = {{(`RV_XLEN-16){!loadUnsigned && shifted[15]}}, shifted[15:0]};
            default:     rdata = shifted;
        endcase
    end

endmodule

// File: design/rvCore.sv
`include "rvCore_config.svh"

module rvCore (
    input  logic                clk,
    input  logic                arstN,
    input  logic                instrValid,
    input  logic [31:0]         instr,
    output logic [`RV_XLEN-1:0] pc,
    output rvPkg::wbT           wb
);

    rvPkg::ctrlT         ctrl;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rdata1;
    logic [`RV_XLEN-1:0] rdata2;
    logic [`RV_XLEN-1:0] aluB;
    logic [`RV_XLEN-1:0] aluResult;
    logic                aluEq;
    logic                aluLt;
    logic                aluLtu;
    logic [`RV_XLEN-1:0] memRdata;
    logic [`RV_XLEN-1:0] loadData;
    logic [`RV_XLEN-1:0] pcPlus4;
    logic [`RV_XLEN-1:0] nextPc;
    logic [`RV_XLEN-1:0] wbData;
    logic                taken;
    logic [4:0]          rd;

    assign rd = instr[11:7];

    controlUnit ctrl0 (.instr(instr), .ctrl(ctrl));
    immGen      imm0  (.instr(instr), .imm(imm));

    regFile regs0 (
        .clk    (clk),
        .arstN  (arstN),
        .rs1    (instr[19:15]),
        .rs2    (instr[24:20]),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (instrValid && ctrl.regWrite),  // Only retired instructions write
        .rd     (rd),
        .wdata  (wbData)
    );

    assign aluB = ctrl.aluSrcImm ? imm : rdata2;

    alu alu0 (
        .op     (ctrl.aluOp),
        .a      (rdata1),
        .b      (aluB),
        .result (aluResult),
        .eq     (aluEq),
        .lt     (aluLt),
        .ltu    (aluLtu)
    );

    dataMem dmem0 (
        .clk          (clk),
        .addr         (aluResult),
        .wdata        (rdata2),
        .we           (instrValid && ctrl.memWrite),
        .size         (ctrl.memSize),
        .loadUnsigned (ctrl.loadUnsigned),
        .rdata        (memRdata)
    );

    ////////////////////////////////////////
    // Branch resolution and next pc
    ////////////////////////////////////////
    always_comb
    begin
        case (ctrl.branchKind)
            rvPkg::EQ:  taken = aluEq;
            rvPkg::NE:  taken = !aluEq;
            rvPkg::LT:  taken = aluLt;
            rvPkg::GE:  taken = !aluLt;
            rvPkg::LTU: taken = aluLtu;
            rvPkg::GEU: taken = !aluLtu;
            default:    taken = 1'b0;
        endcase
    end

    assign pcPlus4 = pc + `RV_XLEN'(4);
    assign nextPc  = ctrl.jumpReg           ? {aluResult[`RV_XLEN-1:1], 1'b0} :
                     (ctrl.jump || taken)   ? pc + imm : pcPlus4;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            pc <= `RV_RESET_PC;
        else if (instrValid)                    // Hold while idle
            pc <= nextPc;
    end

    ////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////
    assign loadData = ctrl.memRead ? memRdata : '0;
    assign wbData   = ctrl.jump ? pcPlus4 : (ctrl.memToReg ? loadData : aluResult);

    assign wb.valid = instrValid && ctrl.regWrite && (rd != 5'd0);
    assign wb.rd    = rd;
    assign wb.data  = wbData;

endmodule

// File: verif/rvCore_sva.sv
`include "rvCore_config.svh"

module rvCore_sva (
    input logic                clk,
    input logic                arstN,
    input logic                instrValid,
    input logic [`RV_XLEN-1:0] pc,
    input rvPkg::wbT           wb
);

    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pc is not word aligned: %08h", pc);

    noWriteToX0: assert property (@(posedge clk) disable iff (!arstN)
        wb.valid |-> wb.rd != 5'd0)
        else $error("wb.valid raised for rd zero");

    // Idle edge must leave the pc untouched
    pcHoldsIdle: assert property (@(posedge clk) disable iff (!arstN)
        !instrValid |=> $stable(pc))
        else $error("pc moved across an idle cycle");

    quietInReset: assert property (@(posedge clk) !arstN |-> !wb.valid)
        else $error("wb.valid high during reset");

endmodule

bind rvCore rvCore_sva sva0 (
    .clk        (clk),
    .arstN      (arstN),
    .instrValid (instrValid),
    .pc         (pc),
    .wb         (wb)
);

// File: verif/rvCoreTb.sv
`include "rvCore_config.svh"

module rvCoreTb;

    localparam int                  numInstr   = 700;
    localparam int                  drainLimit = 50;
    localparam logic [`RV_XLEN-1:0] dataBase   = 32'h0000_0100;   // Held in x31

    logic                clk;
    logic                arstN;
    logic                instrValid;
    logic [31:0]         instr;
    logic [`RV_XLEN-1:0] pc;
    rvPkg::wbT           wb;

    logic [`RV_XLEN-1:0] modelRegs [`RV_REGS];
    logic [`RV_XLEN-1:0] modelMem [`RV_DMEM_WORDS];
    logic [`RV_XLEN-1:0] modelPc;
    logic [31:0]         preamble [$];
    logic [31:0]         rngState;
    int                  issued;
    int                  retired;
    int                  wbErrors;
    int                  pcErrors;

    rvCore dut0 (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .wb         (wb)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Random source and encoders
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvPkg::OP};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rvPkg::STORE};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvPkg::BRANCH};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::JAL};
    endfunction

    // Initial memory contents, a hash of the byte address
    function automatic logic [11:0] fillPattern(input logic [`RV_XLEN-1:0] addr);
        logic [31:0] h;
        h = (addr ^ 32'h5bd1_e995) * 32'h9e37_79b1;
        return h[31:20];
    endfunction

    ////////////////////////////////////////
    // Program generation
    ////////////////////////////////////////
    task automatic buildPreamble();
        logic [`RV_XLEN-1:0] addr;
        preamble.push_back(rType(7'h00, 5'd10, 5'd9, 3'b110, 5'd4));    // Reset regs read zero
        preamble.push_back(rType(7'h00, 5'd0, 5'd0, 3'b000, 5'd5));
        preamble.push_back(iType(dataBase[11:0], 5'd0, 3'b000, 5'd31, rvPkg::OP_IMM));
        for (int k = 0; k < 16; k++)
        begin
            addr = dataBase + 32'(4 * k);
            preamble.push_back(iType(fillPattern(addr), 5'd0, 3'b000, 5'd1, rvPkg::OP_IMM));
            preamble.push_back(sType(12'(4 * k), 5'd1, 5'd31, 3'b010));
        end
        // Sign edge operands for shifts and compares
        preamble.push_back(iType(12'hfff, 5'd0, 3'b000, 5'd2, rvPkg::OP_IMM));
        preamble.push_back(iType(12'h01f, 5'd2, 3'b001, 5'd3, rvPkg::OP_IMM));
        preamble.push_back(iType(12'h001, 5'd2, 3'b101, 5'd6, rvPkg::OP_IMM));
        preamble.push_back(iType(12'h404, 5'd3, 3'b101, 5'd7, rvPkg::OP_IMM));
        preamble.push_back(rType(7'h00, 5'd6, 5'd3, 3'b010, 5'd8));
        preamble.push_back(rType(7'h00, 5'd6, 5'd3, 3'b011, 5'd9));
        preamble.push_back(rType(7'h20, 5'd6, 5'd3, 3'b101, 5'd10));
    endtask

    function automatic logic [31:0] genInstr();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  cand;
        logic [2:0]  f3;
        logic [11:0] off;
        logic [31:0] step;
        logic [31:0] target;
        logic [31:0] delta;
        logic        found;
        logic [31:0] result;
        r    = nextRand();
        s    = nextRand();
        rd   = 5'(s[9:0] % 31);                 // Never x31
        rs1  = s[14:10];
        rs2  = s[19:15];
        f3   = s[22:20];
        step = {r[9:8], 2'b00} + 32'd4;         // Forward 4 to 16 bytes
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3:
            begin
                result = rType((f3 == 3'b000 || f3 == 3'b101) && s[23] ? 7'h20 : 7'h00,
                               rs2, rs1, f3, rd);
            end
            4'd4, 4'd5, 4'd6:
            begin
                if (f3 == 3'b001)
                    off = {7'h00, s[28:24]};
                else if (f3 == 3'b101)
                    off = {s[23] ? 7'h20 : 7'h00, s[28:24]};
                else
                    off = r[31:20];
                result = iType(off, rs1, f3, rd, rvPkg::OP_IMM);
            end
            4'd7:
            begin
                if (f3[1:0] == 2'b11 || f3 == 3'b110)
                    f3 = 3'b010;
                off = {6'h00, r[13:8]};
                if (f3[1:0] == 2'b01)
                    off[0] = 1'b0;
                if (f3[1:0] == 2'b10)
                    off[1:0] = 2'b00;
                result = iType(off, 5'd31, f3, rd, rvPkg::LOAD);
            end
            4'd8, 4'd9:
            begin
                f3  = {1'b0, (s[21:20] == 2'b11) ? 2'b10 : s[21:20]};
                off = {6'h00, r[13:8]};
                if (f3[1:0] == 2'b01)
                    off[0] = 1'b0;
                if (f3[1:0] == 2'b10)
                    off[1:0] = 2'b00;
                result = sType(off, rs2, 5'd31, f3);
            end
            4'd10, 4'd11:
            begin
                if (f3[2:1] == 2'b01)
                    f3 = f3 ^ 3'b110;           // Skip reserved func3
                result = bType(13'(step), r[10] ? rs1 : rs2, rs1, f3);
            end
            4'd12:
            begin
                result = jType(21'(step), rd);
            end
            4'd13:
            begin
                target = modelPc + step;
                found  = 1'b0;
                off    = '0;
                for (int k = 0; k < 32; k++)
                begin
                    cand  = s[14:10] + 5'(k);
                    delta = target - modelRegs[cand] + {31'b0, r[10]};
                    if (!found && $signed(delta) >= -2048 && $signed(delta) <= 2047)
                    begin
                        found = 1'b1;
                        rs1   = cand;
                        off   = delta[11:0];
                    end
                end
                if (found)
                    result = iType(off, rs1, 3'b000, rd, rvPkg::JALR);
                else
                    result = jType(21'(step), rd);
            end
            4'd14:
            begin
                result = {r[31:7], r[5] ? (r[4] ? 7'b0110111 : 7'b0010111) :
                                          (r[4] ? 7'b1110011 : 7'b0001111)};
            end
            default:
            begin
                result = rType(7'h00, rs2, rs1, f3, 5'd0);      // Discarded write
            end
        endcase
        return result;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'b000: res = alt ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = {31'b0, $signed(a) < $signed(b)};
            3'b011: res = {31'b0, a < b};
            3'b100: res = a ^ b;
            3'b101:
            begin
                if (alt)
                    res = $signed(a) >>> b[4:0];
                else
                    res = a >> b[4:0];
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic rvPkg::wbT refStep(input logic [31:0] ins,
                                          output logic [`RV_XLEN-1:0] nextPc);
        rvPkg::wbT   exp;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] addr;
        logic [31:0] word;
        logic [1:0]  sel;
        logic [2:0]  f3;
        logic        take;
        int          idx;
        f3   = ins[14:12];
        a    = modelRegs[ins[19:15]];
        b    = modelRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        exp    = '0;
        exp.rd = ins[11:7];
        nextPc = modelPc + 32'd4;
        case (ins[6:0])
            7'b0110011:
            begin
                exp.valid = 1'b1;
                exp.data  = aluRef(f3, ins[30], a, b);
            end
            7'b0010011:
            begin
                exp.valid = 1'b1;
                exp.data  = aluRef(f3, ins[30] && f3 == 3'b101, a, immI);
            end
            7'b0000011:
            begin
                addr = a + immI;
                idx  = int'((addr >> 2) % `RV_DMEM_WORDS);
                word = modelMem[idx] >> (8 * addr[1:0]);
                case (f3[1:0])
                    2'b00:   exp.data = {{24{!f3[2] && word[7]}}, word[7:0]};
                    2'b01:   exp.data = {{16{!f3[2] && word[15]}}, word[15:0]};
                    default: exp.data = word;
                endcase
                exp.valid = 1'b1;
            end
            7'b0100011:
            begin
                addr = a + immS;
                idx  = int'((addr >> 2) % `RV_DMEM_WORDS);
                sel  = (f3[1:0] == 2'b00) ? 2'b00 : (f3[1:0] == 2'b01) ? 2'b01 : 2'b11;
                for (int lane = 0; lane < 4; lane++)
                begin
                    if ((2'(lane) & ~sel) == (addr[1:0] & ~sel))
                        modelMem[idx][8*lane +: 8] = b[8*(2'(lane) & sel) +: 8];
                end
            end
            7'b1100011:
            begin
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = !($signed(a) < $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = !(a < b);
                    default: take = 1'b0;
                endcase
                if (take)
                    nextPc = modelPc + immB;
            end
            7'b1101111:
            begin
                exp.valid = 1'b1;
                exp.data  = modelPc + 32'd4;
                nextPc    = modelPc + immJ;
            end
            7'b1100111:
            begin
                if (f3 == 3'b000)
                begin
                    exp.valid = 1'b1;
                    exp.data  = modelPc + 32'd4;
                    nextPc    = (a + immI) & ~32'd1;
                end
            end
            default:
            begin
                exp.valid = 1'b0;                   // Unknown opcode, plain pc + 4
            end
        endcase
        if (exp.rd == 5'd0)
            exp.valid = 1'b0;
        if (exp.valid)
            modelRegs[exp.rd] = exp.data;
        return exp;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic checkWb(input rvPkg::wbT exp, input rvPkg::wbT act);
        if (exp.valid !== act.valid ||
            (exp.valid && (exp.rd !== act.rd || exp.data !== act.data)))
        begin
            wbErrors++;
            $display("ERROR at %0t: wb expected valid %0b rd %0d data %08h, got %0b %0d %08h",
                     $time, exp.valid, exp.rd, exp.data, act.valid, act.rd, act.data);
        end
    endtask

    task automatic checkPc(input logic [`RV_XLEN-1:0] exp, input logic [`RV_XLEN-1:0] act);
        if (exp !== act)
        begin
            pcErrors++;
            $display("ERROR at %0t: pc expected %08h, got %08h", $time, exp, act);
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk)
    begin
        rvPkg::wbT           exp;
        logic [`RV_XLEN-1:0] np;
        if (!arstN)
        begin
            checkPc(`RV_RESET_PC, pc);
            checkWb('0, wb);
        end
        else if (instrValid)
        begin
            checkPc(modelPc, pc);
            exp = refStep(instr, np);
            checkWb(exp, wb);
            modelPc = np;
            retired++;
        end
        else
        begin
            checkPc(modelPc, pc);
            checkWb('0, wb);
        end
    end

    task automatic waitDrained();
        int cycles;
        cycles = 0;
        while (retired < issued && cycles < drainLimit)
        begin
            @(posedge clk);
            cycles++;
        end
        if (retired < issued)
        begin
            $display("Timeout: only %0d of %0d issued instructions retired", retired, issued);
            $display("** FAIL **");
            $finish;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial
    begin
        logic [31:0] roll;
        logic [31:0] next;
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        rngState   = 32'hf65c;
        issued     = 0;
        retired    = 0;
        wbErrors   = 0;
        pcErrors   = 0;
        modelPc    = `RV_RESET_PC;
        for (int i = 0; i < `RV_REGS; i++)
            modelRegs[i] = '0;
        for (int i = 0; i < `RV_DMEM_WORDS; i++)
            modelMem[i] = '0;
        buildPreamble();

        repeat (3) @(posedge clk);
        arstN <= 1'b1;

        while (issued < numInstr)
        begin
            @(posedge clk);
            roll = nextRand();
            if (preamble.size() == 0 && roll[3:0] == 4'h0)
            begin
                instrValid <= 1'b0;
                instr      <= roll;                 // Junk while idle
            end
            else
            begin
                if (preamble.size() > 0)
                    next = preamble.pop_front();
                else
                    next = genInstr();
                instrValid <= 1'b1;
                instr      <= next;
                issued++;
            end
        end
        @(posedge clk);
        instrValid <= 1'b0;
        waitDrained();

        $display("Done: %0d instructions, %0d wb errors, %0d pc errors",
                 retired, wbErrors, pcErrors);
        if (wbErrors == 0 && pcErrors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
design/rvPkg.sv
design/controlUnit.sv
design/immGen.sv
design/regFile.sv
design/alu.sv
design/dataMem.sv
design/rvCore.sv
verif/rvCore_sva.sv
verif/rvCoreTb.sv

// File: runSim.sh
#!/bin/sh
# Build the rvCore testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rvCoreTb -f build.f -o rvCoreSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/rvCoreSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

# A simulator stop, such as a failed assertion, counts as a failed run
if [ $simStatus -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
    echo "** FAIL **" >> "$LOG"
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
